//--- vlog.f
hdl/mipsIsaPkg.sv
hdl/mipsCtrlPkg.sv
hdl/ctrlBus.sv
hdl/regFile.sv
hdl/controlFsm.sv
hdl/dataPath.sv
hdl/wbMaster.sv
hdl/mipsCore.sv
tests/wbBus_assert.sv
tests/coreChecker.sv
tests/mipsCoreTb.sv

//--- run.sh
#!/bin/bash
# Build the testbench with Verilator, run it and look for the pass line
verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module mipsCoreTb -o mipsCoreSim \
	&& ./obj_dir/mipsCoreSim +verilator+error+limit+100 | tee /dev/stderr | grep "STATUS: PASS" > /dev/null \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }

//--- tests/testdata.hex
// Program image and load data fill words 0 to 63
// Expected events from word 64 as kind address value with kind 1 a store and kind 2 a fetch
// A word of all ones ends the event table
@00
20010007 2002FFFD 00221820 AC030200 00222022 AC040204 00222824 AC050208
20000055 AC00020C 8C0600C0 24C70100 AC070210 8C0800C4 25090001 AC090214
10210001 AC0102F0 14220001 AC0202F4 10220001 AC010218 14210001 AC02021C
0800001A AC0102F8 200A0033 01085020 AC0A0224 FC000000 AC0B0228 0000000D
// Exception handler at 0x80
@20
15600003 240B00E1 AC0B0230 0800001C 240B00E2 AC0B0234 0800001E
// Load data at 0xC0
@30
12345678 7FFFFFFF
@40
00000001 00000200 00000004
00000001 00000204 0000000A
00000001 00000208 00000005
00000001 0000020C 00000000
00000001 00000210 12345778
00000001 00000214 80000000
00000001 00000218 00000007
00000001 0000021C FFFFFFFD
00000002 00000080 00000000
00000001 00000230 000000E1
00000001 00000224 00000033
00000002 00000080 00000000
00000001 00000234 000000E2
00000001 00000228 000000E2
00000002 0000007C 00000000
FFFFFFFF

//--- tests/mipsCoreTb.sv
`timescale 1ns/1ps

module mipsCoreTb;
	import mipsIsaPkg::*;

	localparam int ProgramWords = 64;
	localparam int TableWords = 64;
	localparam int CycleLimit = ProgramWords * 4 * 5 + 200;
	localparam int QuietCycles = 20; // Bus watched this long after halt
	localparam wordT ExceptionVector = 32'h80;

	logic Clk, Reset;
	logic WbCyc, WbStb, WbWe, WbAck, Halted;
	wordT WbAdr, WbDatO, WbDatI;
	wordT memory [1024];
	wordT eventTable [TableWords];
	logic [31:0] lcgState;
	int waitLeft;
	logic waiting;
	logic runDone, reportDone, timedOut;
	int failCount, cycleCount;

	mipsCore #(
		.ResetVector(32'h0),
		.ExceptionVector(ExceptionVector)
	) mipsCore_inst (
		.Clk(Clk),
		.Reset(Reset),
		.WbCyc(WbCyc),
		.WbStb(WbStb),
		.WbWe(WbWe),
		.WbAdr(WbAdr),
		.WbDatO(WbDatO),
		.WbDatI(WbDatI),
		.WbAck(WbAck),
		.Halted(Halted)
	);

	coreChecker #(
		.TableWords(TableWords)
	) coreChecker_inst (
		.Clk(Clk),
		.Reset(Reset),
		.WbStb(WbStb),
		.WbWe(WbWe),
		.WbAck(WbAck),
		.WbAdr(WbAdr),
		.WbDatO(WbDatO),
		.Halted(Halted),
		.eventTable(eventTable),
		.runDone(runDone),
		.failCount(failCount),
		.reportDone(reportDone)
	);

	always #20 Clk = ~Clk;

	function automatic logic [31:0] nextRandom(logic [31:0] state);
		return state * 32'd1103515245 + 32'd12345;
	endfunction

	// Memory model acks after 0 to 3 wait states
	always @(negedge Clk) begin
		if (Reset || WbAck) begin
			WbAck <= 1'b0;
		end else if (WbStb) begin
			if (!waiting) begin
				lcgState = nextRandom(lcgState);
				waitLeft = int'(lcgState[17:16]);
				waiting = 1'b1;
			end
			if (waitLeft == 0) begin
				waiting = 1'b0;
				WbAck <= 1'b1;
				WbDatI <= memory[WbAdr[11:2]];
				if (WbWe)
					memory[WbAdr[11:2]] <= WbDatO;
			end else begin
				waitLeft = waitLeft - 1;
			end
		end
	end

	initial begin
		Clk = 1'b0;
		Reset = 1'b1;
		WbAck = 1'b0;
		WbDatI = '0;
		runDone = 1'b0;
		timedOut = 1'b0;
		waiting = 1'b0;
		waitLeft = 0;
		lcgState = 32'hc066;
		for (int i = 0; i < 1024; i++)
			memory[i] = {i[15:0] ^ 16'hA5A5, ~i[15:0]};
		$readmemh("tests/testdata.hex", memory);
		for (int i = 0; i < TableWords; i++)
			eventTable[i] = memory[ProgramWords + i]; // Expected events follow the program
		repeat (16) @(posedge Clk);
		@(negedge Clk);
		Reset = 1'b0;
		cycleCount = 0;
		while (!Halted && cycleCount < CycleLimit) begin
			@(negedge Clk);
			cycleCount++;
		end
		if (!Halted) begin
			timedOut = 1'b1;
			$display("Timeout: core did not halt within %0d cycles", CycleLimit);
		end else begin
			repeat (QuietCycles) @(negedge Clk);
		end
		@(negedge Clk);
		runDone = 1'b1;
		wait (reportDone);
		if (failCount == 0 && !timedOut && mipsCore_inst.wbBusAssert_inst.violations == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

//--- tests/coreChecker.sv
`timescale 1ns/1ps

module coreChecker #(
	parameter int TableWords = 64
) (
	input logic Clk,
	input logic Reset,
	input logic WbStb,
	input logic WbWe,
	input logic WbAck,
	input mipsIsaPkg::wordT WbAdr,
	input mipsIsaPkg::wordT WbDatO,
	input logic Halted,
	input mipsIsaPkg::wordT eventTable [TableWords],
	input logic runDone,
	output int failCount,
	output logic reportDone
);
	import mipsIsaPkg::*;

	localparam wordT TableEnd = 32'hFFFF_FFFF;
	localparam wordT StoreKind = 32'd1;
	localparam wordT FetchKind = 32'd2;

	int eventIdx; // Word index of the next expected event
	int passCount;
	logic haltSeen;
	logic busAfterHalt;

	task automatic matchAccess();
		wordT kind;
		int num;
		kind = (eventIdx + 2 < TableWords) ? eventTable[eventIdx] : TableEnd;
		num = eventIdx / 3;
		if (kind == FetchKind) begin
			if (WbWe) begin
				$display("FAIL event %0d: store to 0x%08h came before the expected fetch",
					num, WbAdr);
				failCount++;
			end else if (WbAdr == eventTable[eventIdx + 1]) begin
				$display("PASS event %0d: fetch from 0x%08h", num, WbAdr);
				passCount++;
				eventIdx += 3;
			end
		end else if (WbWe && kind != StoreKind) begin
			$display("FAIL: store to 0x%08h after the last expected event", WbAdr);
			failCount++;
		end else if (WbWe) begin
			if (WbAdr != eventTable[eventIdx + 1]) begin
				$display("CHECK FAILED event %0d: WbAdr = 0x%08h, expected 0x%08h",
					num, WbAdr, eventTable[eventIdx + 1]);
				failCount++;
			end else if (WbDatO != eventTable[eventIdx + 2]) begin
				$display("CHECK FAILED event %0d: WbDatO = 0x%08h, expected 0x%08h",
					num, WbDatO, eventTable[eventIdx + 2]);
				failCount++;
			end else begin
				$display("PASS event %0d: store 0x%08h to 0x%08h", num, WbDatO, WbAdr);
				passCount++;
			end
			eventIdx += 3;
		end
	endtask

	initial begin
		eventIdx = 0;
		passCount = 0;
		failCount = 0;
		haltSeen = 1'b0;
		busAfterHalt = 1'b0;
		reportDone = 1'b0;
	end

	always @(posedge Clk) begin
		if (!Reset && WbStb && WbAck && !haltSeen)
			matchAccess();
		if (haltSeen && WbStb)
			busAfterHalt = 1'b1;
		if (!Reset && Halted)
			haltSeen = 1'b1;
		if (runDone && !reportDone) begin
			while (eventIdx + 2 < TableWords && eventTable[eventIdx] != TableEnd) begin
				$display("FAIL event %0d: expected %s at 0x%08h was never seen", eventIdx / 3,
					(eventTable[eventIdx] == StoreKind) ? "store" : "fetch",
					eventTable[eventIdx + 1]);
				failCount++;
				eventIdx += 3;
			end
			if (!haltSeen) begin
				$display("FAIL halt: Halted never rose");
				failCount++;
			end else if (busAfterHalt) begin
				$display("FAIL halt: a bus cycle started after Halted rose");
				failCount++;
			end else begin
				$display("PASS halt: Halted high and the bus stayed quiet");
				passCount++;
			end
			$display("Summary: %0d passed, %0d failed", passCount, failCount);
			reportDone = 1'b1;
		end
	end

endmodule

//--- tests/wbBus_assert.sv
`timescale 1ns/1ps

module wbBusAssert (
	input logic Clk,
	input logic Reset,
	input logic WbCyc,
	input logic WbStb,
	input logic WbWe,
	input mipsIsaPkg::wordT WbAdr,
	input mipsIsaPkg::wordT WbDatO,
	input logic WbAck,
	input logic Halted
);
	int violations = 0;

	stbInCycle: assert property (@(posedge Clk) disable iff (Reset) WbStb |-> WbCyc)
		else begin
			$error("WbStb high outside a WbCyc cycle");
			violations++;
		end

	// Master holds the request until the slave acks
	holdUntilAck: assert property (@(posedge Clk) disable iff (Reset)
		WbStb && !WbAck |=> WbStb && $stable(WbAdr) && $stable(WbDatO) && $stable(WbWe))
		else begin
			$error("WbStb request changed before WbAck");
			violations++;
		end

	quietWhenHalted: assert property (@(posedge Clk) disable iff (Reset) Halted |-> !WbStb)
		else begin
			$error("WbStb raised while Halted");
			violations++;
		end

endmodule

bind mipsCore wbBusAssert wbBusAssert_inst (
	.Clk(Clk),
	.Reset(Reset),
	.WbCyc(WbCyc),
	.WbStb(WbStb),
	.WbWe(WbWe),
	.WbAdr(WbAdr),
	.WbDatO(WbDatO),
	.WbAck(WbAck),
	.Halted(Halted)
);

//--- hdl/mipsCore.sv
`timescale 1ns/1ps

module mipsCore #(
	parameter mipsIsaPkg::wordT ResetVector = '0,
	parameter mipsIsaPkg::wordT ExceptionVector = 32'h80
) (
	input logic Clk,
	input logic Reset,
	output logic WbCyc,
	output logic WbStb,
	output logic WbWe,
	output mipsIsaPkg::wordT WbAdr,
	output mipsIsaPkg::wordT WbDatO,
	input mipsIsaPkg::wordT WbDatI,
	input logic WbAck,
	output logic Halted
);
	ctrlIf ctrl ();
	memIf mem ();

	controlFsm controlFsm_inst (
		.Clk(Clk),
		.Reset(Reset),
		.ctrl(ctrl.Seq),
		.mem(mem.Seq),
		.Halted(Halted)
	);

	dataPath #(
		.ResetVector(ResetVector),
		.ExceptionVector(ExceptionVector)
	) dataPath_inst (
		.Clk(Clk),
		.Reset(Reset),
		.ctrl(ctrl.Dp),
		.mem(mem.Dp)
	);

	wbMaster wbMaster_inst (
		.Clk(Clk),
		.Reset(Reset),
		.mem(mem.Bus),
		.WbCyc(WbCyc),
		.WbStb(WbStb),
		.WbWe(WbWe),
		.WbAdr(WbAdr),
		.WbDatO(WbDatO),
		.WbDatI(WbDatI),
		.WbAck(WbAck)
	);

endmodule

//--- hdl/wbMaster.sv
`timescale 1ns/1ps

module wbMaster (
	input logic Clk,
	input logic Reset,
	memIf.Bus mem,
	output logic WbCyc,
	output logic WbStb,
	output logic WbWe,
	output mipsIsaPkg::wordT WbAdr,
	output mipsIsaPkg::wordT WbDatO,
	input mipsIsaPkg::wordT WbDatI,
	input logic WbAck
);
	typedef enum logic {Idle, Busy} busStateT;

	busStateT state;
	logic ackSeen;

	assign ackSeen = WbStb && WbAck;

	always_ff @(posedge Clk or posedge Reset) begin
		if (Reset) begin
			state <= Idle;
			WbCyc <= 1'b0;
			WbStb <= 1'b0;
			WbWe <= 1'b0;
			mem.done <= 1'b0;
		end else begin
			mem.done <= 1'b0;
			case (state)
				Idle: if (mem.req) begin
					state <= Busy;
					WbCyc <= 1'b1;
					WbStb <= 1'b1;
					WbWe <= mem.we;
				end
				default: if (ackSeen) begin // Drop the cycle right after Ack
					state <= Idle;
					WbCyc <= 1'b0;
					WbStb <= 1'b0;
					WbWe <= 1'b0;
					mem.done <= 1'b1;
				end
			endcase
		end
	end

	always_ff @(posedge Clk) begin
		if (state == Idle && mem.req) begin
			WbAdr <= mem.addr;
			WbDatO <= mem.wrData;
		end
		if (ackSeen)
			mem.rdData <= WbDatI;
	end

endmodule

//--- hdl/dataPath.sv
`timescale 1ns/1ps

module dataPath #(
	parameter mipsIsaPkg::wordT ResetVector = '0,
	parameter mipsIsaPkg::wordT ExceptionVector = 32'h80
) (
	input logic Clk,
	input logic Reset,
	ctrlIf.Dp ctrl,
	memIf.Dp mem
);
	import mipsIsaPkg::*;
	import mipsCtrlPkg::*;

	wordT pc, ir, regA, regB, aluOut, mdr, epc;
	wordT rfDataA, rfDataB, rfWrData;
	wordT aluA, aluB, aluResult, pcNext;
	regAddrT wrAddr;
	immT imm;
	jumpT target;
	logic aluZero;

	assign imm = ir[15:0];
	assign target = ir[25:0];
	assign ctrl.opcode = opcodeT'(ir[31:26]);
	assign ctrl.funct = functT'(ir[5:0]);
	assign ctrl.instrZero = (ir == '0);

	assign wrAddr = ctrl.regDstRd ? ir[15:11] : ir[20:16];
	assign rfWrData = ctrl.memToReg ? mdr : aluOut;

	regFile regFile_inst (
		.Clk(Clk),
		.Reset(Reset),
		.rdAddrA(ir[25:21]),
		.rdAddrB(ir[20:16]),
		.wrAddr(wrAddr),
		.wrEn(ctrl.regWrite),
		.wrData(rfWrData),
		.rdDataA(rfDataA),
		.rdDataB(rfDataB)
	);

	assign aluA = (ctrl.srcA == RegA) ? regA : pc;

	always_comb begin
		case (ctrl.srcB)
			RegB: aluB = regB;
			Four: aluB = 32'd4;
			SignImm: aluB = signExt(imm);
			default: aluB = signExt(imm) << 2;
		endcase
		case (ctrl.aluOp)
			Sub: aluResult = aluA - aluB;
			And: aluResult = aluA & aluB;
			default: aluResult = aluA + aluB;
		endcase
		case (ctrl.aluOp)
			Add: ctrl.overflow = (aluA[31] == aluB[31]) && (aluResult[31] != aluA[31]);
			Sub: ctrl.overflow = (aluA[31] != aluB[31]) && (aluResult[31] != aluA[31]);
			default: ctrl.overflow = 1'b0;
		endcase
		case (ctrl.pcSrc)
			AluResult: pcNext = aluResult;
			AluOut: pcNext = aluOut;
			JumpTarget: pcNext = jumpAddr(pc, target);
			default: pcNext = ExceptionVector;
		endcase
	end

	assign aluZero = (aluResult == '0);

	always_ff @(posedge Clk or posedge Reset) begin
		if (Reset) begin
			pc <= ResetVector;
			ir <= '0;
		end else begin
			if (ctrl.pcWrite || (ctrl.branchWrite && (aluZero != ctrl.branchNe)))
				pc <= pcNext;
			if (ctrl.irWrite && mem.done)
				ir <= mem.rdData;
		end
	end

	always_ff @(posedge Clk) begin
		regA <= rfDataA;
		regB <= rfDataB;
		aluOut <= aluResult;
		if (mem.done && !ctrl.irWrite)
			mdr <= mem.rdData; // Load data
		if (ctrl.epcWrite)
			epc <= aluResult;
	end

	assign mem.addr = ctrl.addrFromAlu ? aluOut : pc;
	assign mem.wrData = regB;

endmodule

//--- hdl/controlFsm.sv
`timescale 1ns/1ps

module controlFsm (
	input logic Clk,
	input logic Reset,
	ctrlIf.Seq ctrl,
	memIf.Seq mem,
	output logic Halted
);
	import mipsIsaPkg::*;
	import mipsCtrlPkg::*;

	seqStateT state, nextState;
	logic memAccess; // State owns a bus access
	logic reqPending;

	always_ff @(posedge Clk or posedge Reset) begin
		if (Reset) begin
			state <= Fetch;
			reqPending <= 1'b0;
		end else begin
			state <= nextState;
			if (mem.req)
				reqPending <= 1'b1;
			else if (mem.done)
				reqPending <= 1'b0;
		end
	end

	assign mem.req = memAccess && !reqPending;
	assign Halted = (state == Halt);

	always_comb begin
		ctrl.aluOp = Add;
		ctrl.srcA = Pc;
		ctrl.srcB = Four;
		ctrl.pcSrc = AluResult;
		ctrl.pcWrite = 1'b0;
		ctrl.branchWrite = 1'b0;
		ctrl.branchNe = 1'b0;
		ctrl.irWrite = 1'b0;
		ctrl.regWrite = 1'b0;
		ctrl.regDstRd = 1'b0;
		ctrl.memToReg = 1'b0;
		ctrl.addrFromAlu = 1'b0;
		ctrl.epcWrite = 1'b0;
		mem.we = 1'b0;
		memAccess = 1'b0;
		nextState = state;
		case (state)
			Fetch: begin
				memAccess = 1'b1;
				ctrl.irWrite = mem.done;
				ctrl.pcWrite = mem.done; // PC + 4 with the new IR
				if (mem.done)
					nextState = Decode;
			end
			Decode: begin
				ctrl.srcB = ShiftedImm; // Branch target into ALUOut
				case (ctrl.opcode)
					RTYPE: begin
						case (ctrl.funct)
							ADD, SUB, AND: nextState = ArithExec;
							BREAK: nextState = Halt;
							SLL: nextState = ctrl.instrZero ? Fetch : Except;
							default: nextState = Except;
						endcase
					end
					BEQ, BNE: nextState = Branch;
					J: nextState = Jump;
					ADDI, ADDIU: nextState = ImmExec;
					LW, SW: nextState = MemAddr;
					default: nextState = Except;
				endcase
			end
			ArithExec, ArithWrite: begin
				ctrl.srcA = RegA;
				ctrl.srcB = RegB;
				case (ctrl.funct)
					SUB: ctrl.aluOp = Sub;
					AND: ctrl.aluOp = And;
					default: ctrl.aluOp = Add;
				endcase
				if (state == ArithWrite) begin
					ctrl.regWrite = 1'b1;
					ctrl.regDstRd = 1'b1;
					nextState = Fetch;
				end else begin
					nextState = ctrl.overflow ? Except : ArithWrite; // Never set for AND
				end
			end
			ImmExec, ImmWrite: begin
				ctrl.srcA = RegA;
				ctrl.srcB = SignImm;
				if (state == ImmWrite) begin
					ctrl.regWrite = 1'b1;
					nextState = Fetch;
				end else if (ctrl.overflow && ctrl.opcode == ADDI) begin
					nextState = Except;
				end else begin
					nextState = ImmWrite; // ADDIU wraps
				end
			end
			MemAddr, LoadRead, LoadWrite, StoreWrite: begin
				ctrl.srcA = RegA;
				ctrl.srcB = SignImm;
				ctrl.addrFromAlu = 1'b1;
				case (state)
					MemAddr: nextState = (ctrl.opcode == LW) ? LoadRead : StoreWrite;
					LoadWrite: begin
						ctrl.regWrite = 1'b1;
						ctrl.memToReg = 1'b1;
						nextState = Fetch;
					end
					default: begin
						memAccess = 1'b1;
						mem.we = (state == StoreWrite);
						if (mem.done)
							nextState = (state == LoadRead) ? LoadWrite : Fetch;
					end
				endcase
			end
			Branch: begin
				ctrl.srcA = RegA;
				ctrl.srcB = RegB;
				ctrl.aluOp = Sub;
				ctrl.pcSrc = AluOut;
				ctrl.branchWrite = 1'b1;
				ctrl.branchNe = (ctrl.opcode == BNE);
				nextState = Fetch;
			end
			Jump: begin
				ctrl.pcSrc = JumpTarget;
				ctrl.pcWrite = 1'b1;
				nextState = Fetch;
			end
			Except: begin
				ctrl.aluOp = Sub; // PC - 4 is the trapping instruction
				ctrl.epcWrite = 1'b1;
				ctrl.pcSrc = Vector;
				ctrl.pcWrite = 1'b1;
				nextState = Fetch;
			end
			default: nextState = Halt;
		endcase
	end

endmodule

//--- hdl/regFile.sv
`timescale 1ns/1ps

module regFile (
	input logic Clk,
	input logic Reset,
	input mipsIsaPkg::regAddrT rdAddrA,
	input mipsIsaPkg::regAddrT rdAddrB,
	input mipsIsaPkg::regAddrT wrAddr,
	input logic wrEn,
	input mipsIsaPkg::wordT wrData,
	output mipsIsaPkg::wordT rdDataA,
	output mipsIsaPkg::wordT rdDataB
);
	import mipsIsaPkg::*;

	wordT regs [32];

	always_ff @(posedge Clk or posedge Reset) begin
		if (Reset) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (wrEn && wrAddr != '0) begin // $zero never written
			regs[wrAddr] <= wrData;
		end
	end

	assign rdDataA = regs[rdAddrA];
	assign rdDataB = regs[rdAddrB];

endmodule

//--- hdl/ctrlBus.sv
`timescale 1ns/1ps

interface ctrlIf;
	import mipsIsaPkg::*;
	import mipsCtrlPkg::*;

	aluOpT aluOp;
	srcAT srcA;
	srcBT srcB;
	pcSrcT pcSrc;
	logic pcWrite, branchWrite, branchNe, irWrite;
	logic regWrite, regDstRd, memToReg, addrFromAlu, epcWrite;
	opcodeT opcode;
	functT funct;
	logic overflow;
	logic instrZero; // Whole IR is zero

	modport Seq (output aluOp, srcA, srcB, pcSrc, pcWrite, branchWrite, branchNe, irWrite,
		regWrite, regDstRd, memToReg, addrFromAlu, epcWrite,
		input opcode, funct, overflow, instrZero);
	modport Dp (input aluOp, srcA, srcB, pcSrc, pcWrite, branchWrite, branchNe, irWrite,
		regWrite, regDstRd, memToReg, addrFromAlu, epcWrite,
		output opcode, funct, overflow, instrZero);
endinterface

interface memIf;
	import mipsIsaPkg::*;

	logic req; // One cycle per access
	logic we;
	wordT addr, wrData, rdData;
	logic done; // One cycle with rdData valid

	modport Seq (output req, we, input done);
	modport Dp (output addr, wrData, input rdData, done);
	modport Bus (input req, we, addr, wrData, output rdData, done);
endinterface

//--- hdl/mipsCtrlPkg.sv
package mipsCtrlPkg;

	typedef enum logic [3:0] {
		Fetch,
		Decode,
		ArithExec,
		ArithWrite,
		ImmExec,
		ImmWrite,
		MemAddr,
		LoadRead,
		LoadWrite,
		StoreWrite,
		Branch,
		Jump,
		Except,
		Halt
	} seqStateT;

	typedef enum logic [1:0] {
		Add,
		Sub,
		And
	} aluOpT;

	typedef enum logic {
		Pc,
		RegA
	} srcAT;

	typedef enum logic [1:0] {
		RegB,
		Four,
		SignImm,
		ShiftedImm
	} srcBT;

	typedef enum logic [1:0] {
		AluResult,
		AluOut,
		JumpTarget,
		Vector
	} pcSrcT;

endpackage

//--- hdl/mipsIsaPkg.sv
package mipsIsaPkg;

	typedef logic [31:0] wordT;
	typedef logic [4:0] regAddrT;
	typedef logic [15:0] immT;
	typedef logic [25:0] jumpT;

	typedef enum logic [5:0] {
		RTYPE = 6'h00,
		J = 6'h02,
		BEQ = 6'h04,
		BNE = 6'h05,
		ADDI = 6'h08,
		ADDIU = 6'h09,
		LW = 6'h23,
		SW = 6'h2B
	} opcodeT;

	typedef enum logic [5:0] {
		SLL = 6'h00, // Only as NOP
		BREAK = 6'h0D,
		ADD = 6'h20,
		SUB = 6'h22,
		AND = 6'h24
	} functT;

	function automatic wordT signExt(immT imm);
		return {{16{imm[15]}}, imm};
	endfunction

	// Region of the already incremented PC
	function automatic wordT jumpAddr(wordT pc, jumpT target);
		return {pc[31:28], target, 2'b00};
	endfunction

endpackage
